// File: source/mips_pkg.sv
package mips_pkg;

    localparam int word_width = 32;
    localparam int reg_addr_width = 5;
    localparam int shift_width = 5;
    localparam int jump_index_width = 26;

    localparam logic [word_width-1:0] reset_vector = 32'hBFC00000;
    localparam logic [word_width-1:0] halt_address = 32'h00000000;
    localparam logic [reg_addr_width-1:0] reg_v0 = 5'd2;

    // Primary opcodes, instr[31:26]
    typedef enum logic [5:0] {
        op_special = 6'b000000,
        op_j       = 6'b000010,
        op_beq     = 6'b000100,
        op_bne     = 6'b000101,
        op_addiu   = 6'b001001,
        op_slti    = 6'b001010,
        op_sltiu   = 6'b001011,
        op_andi    = 6'b001100,
        op_ori     = 6'b001101,
        op_xori    = 6'b001110,
        op_lui     = 6'b001111,
        op_lw      = 6'b100011,
        op_sw      = 6'b101011
    } opcode_t;

    // SPECIAL function codes, instr[5:0]
    typedef enum logic [5:0] {
        fn_sll  = 6'b000000,
        fn_srl  = 6'b000010,
        fn_sra  = 6'b000011,
        fn_sllv = 6'b000100,
        fn_srlv = 6'b000110,
        fn_srav = 6'b000111,
        fn_jr   = 6'b001000,
        fn_addu = 6'b100001,
        fn_subu = 6'b100011,
        fn_and  = 6'b100100,
        fn_or   = 6'b100101,
        fn_xor  = 6'b100110,
        fn_slt  = 6'b101010,
        fn_sltu = 6'b101011
    } funct_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass_b
    } alu_op_t;

    typedef enum logic [2:0] {
        br_none,
        br_eq,
        br_ne,
        br_jump,
        br_jump_register
    } branch_kind_t;

    typedef struct packed {
        logic [reg_addr_width-1:0]   rs;
        logic [reg_addr_width-1:0]   rt;
        logic [reg_addr_width-1:0]   write_index;
        logic [word_width-1:0]       immediate;
        logic [shift_width-1:0]      shift_amount;
        alu_op_t                     alu_op;
        logic                        use_immediate;
        logic                        use_variable_shift;
        logic                        reg_write;
        logic                        mem_read;
        logic                        mem_write;
        branch_kind_t                branch_kind;
        logic [jump_index_width-1:0] jump_index;
    } decoded_t;

endpackage

// File: source/mips_decoder.sv
`timescale 1ns/1ps

module mips_decoder import mips_pkg::*; (
    input  logic [word_width-1:0] instr,
    output decoded_t              decoded
);

    opcode_t opcode;
    funct_t funct;
    logic [word_width-1:0] imm_sign;
    logic [word_width-1:0] imm_zero;

    assign opcode = opcode_t'(instr[31:26]);
    assign funct = funct_t'(instr[5:0]);
    assign imm_sign = {{16{instr[15]}}, instr[15:0]};
    assign imm_zero = {16'h0000, instr[15:0]};

    always_comb begin
        decoded = '0;
        decoded.rs = instr[25:21];
        decoded.rt = instr[20:16];
        decoded.write_index = instr[20:16];
        decoded.immediate = imm_sign;
        decoded.shift_amount = instr[10:6];
        decoded.alu_op = alu_add;
        decoded.branch_kind = br_none;
        decoded.jump_index = instr[25:0];

        case (opcode)
            op_special: begin
                decoded.write_index = instr[15:11];
                decoded.reg_write = 1'b1;
                // Variable shifts take their amount from rs
                decoded.use_variable_shift = (funct == fn_sllv) || (funct == fn_srlv)
                                             || (funct == fn_srav);
                case (funct)
                    fn_addu: decoded.alu_op = alu_add;
                    fn_subu: decoded.alu_op = alu_sub;
                    fn_and: decoded.alu_op = alu_and;
                    fn_or: decoded.alu_op = alu_or;
                    fn_xor: decoded.alu_op = alu_xor;
                    fn_slt: decoded.alu_op = alu_slt;
                    fn_sltu: decoded.alu_op = alu_sltu;
                    fn_sll, fn_sllv: decoded.alu_op = alu_sll;
                    fn_srl, fn_srlv: decoded.alu_op = alu_srl;
                    fn_sra, fn_srav: decoded.alu_op = alu_sra;
                    fn_jr: begin
                        decoded.reg_write = 1'b0;
                        decoded.branch_kind = br_jump_register;
                    end
                    default: decoded.reg_write = 1'b0;
                endcase
            end
            op_j: decoded.branch_kind = br_jump;
            op_beq: decoded.branch_kind = br_eq;
            op_bne: decoded.branch_kind = br_ne;
            op_sw: begin
                decoded.use_immediate = 1'b1;
                decoded.mem_write = 1'b1;
            end
            op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lui, op_lw: begin
                decoded.use_immediate = 1'b1;
                decoded.reg_write = 1'b1;
                decoded.mem_read = (opcode == op_lw);
                case (opcode)
                    op_slti: decoded.alu_op = alu_slt;
                    op_sltiu: decoded.alu_op = alu_sltu;
                    op_andi: decoded.alu_op = alu_and;
                    op_ori: decoded.alu_op = alu_or;
                    op_xori: decoded.alu_op = alu_xor;
                    op_lui: decoded.alu_op = alu_pass_b;
                    default: decoded.alu_op = alu_add;
                endcase
                // Logic immediates are zero extended, LUI fills the upper half
                if (opcode == op_andi || opcode == op_ori || opcode == op_xori) begin
                    decoded.immediate = imm_zero;
                end else if (opcode == op_lui) begin
                    decoded.immediate = {instr[15:0], 16'h0000};
                end
            end
            default: decoded.reg_write = 1'b0;
        endcase
    end

endmodule

// File: source/mips_register_file.sv
`timescale 1ns/1ps

module mips_register_file import mips_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [reg_addr_width-1:0] read_a_index,
    input  logic [reg_addr_width-1:0] read_b_index,
    output logic [word_width-1:0]     read_a,
    output logic [word_width-1:0]     read_b,
    input  logic                      write_enable,
    input  logic [reg_addr_width-1:0] write_index,
    input  logic [word_width-1:0]     write_data,
    output logic [word_width-1:0]     v0
);

    localparam int reg_count = 2 ** reg_addr_width;

    logic [word_width-1:0] regs [reg_count];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && write_index != '0) begin
            regs[write_index] <= write_data;
        end
    end

    assign read_a = regs[read_a_index];
    assign read_b = regs[read_b_index];
    assign v0 = regs[reg_v0];

    // $zero holds through any write sequence
    zero_reads_zero: assert property (
        @(posedge clk) disable iff (reset)
        (read_a_index == '0) |-> (read_a == '0)
    );

endmodule

// File: source/mips_alu.sv
`timescale 1ns/1ps

module mips_alu import mips_pkg::*; (
    input  alu_op_t                op,
    input  logic [word_width-1:0]  a,
    input  logic [word_width-1:0]  b,
    input  logic [shift_width-1:0] shift_amount,
    output logic [word_width-1:0]  result
);

    logic signed_less;
    logic unsigned_less;

    assign signed_less = $signed(a) < $signed(b);
    assign unsigned_less = a < b;

    always_comb begin
        case (op)
            alu_add: begin
                result = a + b;
            end
            alu_sub: begin
                result = a - b;
            end
            alu_and: begin
                result = a & b;
            end
            alu_or: begin
                result = a | b;
            end
            alu_xor: begin
                result = a ^ b;
            end
            alu_slt: begin
                result = {{(word_width-1){1'b0}}, signed_less};
            end
            alu_sltu: begin
                result = {{(word_width-1){1'b0}}, unsigned_less};
            end
            // Shifts act on b, the rt operand
            alu_sll: begin
                result = b << shift_amount;
            end
            alu_srl: begin
                result = b >> shift_amount;
            end
            alu_sra: begin
                result = $unsigned($signed(b) >>> shift_amount);
            end
            alu_pass_b: begin
                result = b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: source/mips_pc_unit.sv
`timescale 1ns/1ps

module mips_pc_unit import mips_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          clk_enable,
    input  logic [word_width-1:0]         rs_value,
    input  logic [word_width-1:0]         rt_value,
    input  branch_kind_t                  branch_kind,
    input  logic [word_width-1:0]         immediate,
    input  logic [jump_index_width-1:0]   jump_index,
    output logic [word_width-1:0]         pc,
    output logic                          execute,
    output logic                          active
);

    typedef enum logic {
        st_running,
        st_halted
    } run_state_t;

    run_state_t state;
    logic pending;
    logic [word_width-1:0] pending_target;
    logic [word_width-1:0] pc_next4;
    logic [word_width-1:0] target;
    logic taken;

    assign pc_next4 = pc + 32'd4;
    assign execute = (state == st_running) && clk_enable && (pc != halt_address);

    always_comb begin
        case (branch_kind)
            br_eq: taken = (rs_value == rt_value);
            br_ne: taken = (rs_value != rt_value);
            br_jump, br_jump_register: taken = 1'b1;
            default: taken = 1'b0;
        endcase
        if (branch_kind == br_jump) begin
            target = {pc_next4[31:28], jump_index, 2'b00};
        end else if (branch_kind == br_jump_register) begin
            target = rs_value;
        end else begin
            target = pc_next4 + {immediate[word_width-3:0], 2'b00};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_vector;
            pending <= 1'b0;
            state <= st_running;
            active <= 1'b1;
        end else if (clk_enable && state == st_running && pc == halt_address) begin
            state <= st_halted;
            active <= 1'b0;
        end else if (execute) begin
            // Delay slot runs first, the saved target follows it
            pc <= pending ? pending_target : pc_next4;
            pending <= taken;
            if (taken) begin
                pending_target <= target;
            end
        end
    end

    stays_inactive: assert property (@(posedge clk) disable iff (reset) !active |=> !active);
    pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

// File: source/mips_cpu_harvard.sv
`timescale 1ns/1ps

module mips_cpu_harvard import mips_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    output logic                  active,
    output logic [word_width-1:0] register_v0,

    // Stall input, state only moves while high
    input  logic                  clk_enable,

    // Instruction port, read combinationally
    output logic [word_width-1:0] instr_address,
    input  logic [word_width-1:0] instr_readdata,

    // Data port, combinational read and single-cycle write
    output logic [word_width-1:0] data_address,
    output logic                  data_write,
    output logic                  data_read,
    output logic [word_width-1:0] data_writedata,
    input  logic [word_width-1:0] data_readdata
);

    decoded_t decoded;
    logic [word_width-1:0] pc;
    logic execute;
    logic [word_width-1:0] rs_value;
    logic [word_width-1:0] rt_value;
    logic [word_width-1:0] alu_b;
    logic [shift_width-1:0] shift_amount;
    logic [word_width-1:0] alu_result;
    logic [word_width-1:0] write_data;
    logic write_enable;

    mips_decoder i_decoder (
        .instr   (instr_readdata),
        .decoded (decoded)
    );

    mips_register_file i_register_file (
        .clk          (clk),
        .reset        (reset),
        .read_a_index (decoded.rs),
        .read_b_index (decoded.rt),
        .read_a       (rs_value),
        .read_b       (rt_value),
        .write_enable (write_enable),
        .write_index  (decoded.write_index),
        .write_data   (write_data),
        .v0           (register_v0)
    );

    assign alu_b = decoded.use_immediate ? decoded.immediate : rt_value;
    assign shift_amount = decoded.use_variable_shift ? rs_value[shift_width-1:0]
                                                     : decoded.shift_amount;

    mips_alu i_alu (
        .op           (decoded.alu_op),
        .a            (rs_value),
        .b            (alu_b),
        .shift_amount (shift_amount),
        .result       (alu_result)
    );

    mips_pc_unit i_pc_unit (
        .clk         (clk),
        .reset       (reset),
        .clk_enable  (clk_enable),
        .rs_value    (rs_value),
        .rt_value    (rt_value),
        .branch_kind (decoded.branch_kind),
        .immediate   (decoded.immediate),
        .jump_index  (decoded.jump_index),
        .pc          (pc),
        .execute     (execute),
        .active      (active)
    );

    // Loads return straight from the data port
    assign write_data = decoded.mem_read ? data_readdata : alu_result;
    assign write_enable = decoded.reg_write && execute && (decoded.write_index != '0);

    assign instr_address = pc;
    assign data_address = alu_result;
    assign data_write = decoded.mem_write && execute;
    assign data_read = decoded.mem_read && execute;
    assign data_writedata = rt_value;

    strobes_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(data_read && data_write)
    );

endmodule

// File: test/mips_tb_memory.sv
`timescale 1ns/1ps

module mips_tb_memory import mips_pkg::*; (
    input  logic                  clk,
    input  logic [word_width-1:0] instr_address,
    output logic [word_width-1:0] instr_readdata,
    input  logic [word_width-1:0] data_address,
    input  logic                  data_write,
    input  logic [word_width-1:0] data_writedata,
    output logic [word_width-1:0] data_readdata
);

    logic [word_width-1:0] rom [16];
    logic [word_width-1:0] ram [256];
    logic [word_width-1:0] instr_offset;

    // Byte offset from the reset vector, outside the program reads as a no-op
    assign instr_offset = instr_address - reset_vector;
    assign instr_readdata = (instr_offset < 32'd64) ? rom[instr_offset[5:2]] : '0;

    assign data_readdata = ram[data_address[9:2]];

    always @(posedge clk) begin
        if (data_write) begin
            ram[data_address[9:2]] <= data_writedata;
        end
    end

    task automatic clear();
        for (int i = 0; i < 16; i++) begin
            rom[i] = '0;
        end
    endtask

    task automatic load_word(input int index, input logic [word_width-1:0] value);
        rom[index] = value;
    endtask

endmodule

// File: test/mips_cpu_tb.sv
`timescale 1ns/1ps

module mips_cpu_tb import mips_pkg::*; ();

    typedef struct packed {
        logic [15:0][word_width-1:0] words;
        logic                        stall;
        logic [word_width-1:0]       expected_v0;
        logic [7:0]                  expected_reads;
        logic [7:0]                  expected_writes;
    } test_row_t;

    logic clk;
    logic reset;
    logic clk_enable;
    logic active;
    logic [word_width-1:0] register_v0;
    logic [word_width-1:0] instr_address;
    logic [word_width-1:0] instr_readdata;
    logic [word_width-1:0] data_address;
    logic data_write;
    logic data_read;
    logic [word_width-1:0] data_writedata;
    logic [word_width-1:0] data_readdata;

    test_row_t rows [5];
    string names [5];
    integer seed;
    int errors;
    int passed;
    int failed;
    logic write_while_halted;
    int reads_seen;
    int writes_seen;

    mips_cpu_harvard i_mips_cpu_harvard (.*);

    mips_tb_memory i_memory (.*);

    always #5 clk = ~clk;

    // Data strobes seen on commit edges
    always @(posedge clk) begin
        if (reset) begin
            reads_seen <= 0;
            writes_seen <= 0;
            write_while_halted <= 1'b0;
        end else begin
            if (data_read) begin
                reads_seen <= reads_seen + 1;
            end
            if (data_write) begin
                writes_seen <= writes_seen + 1;
            end
            // Catch any store once the processor has stopped
            if (!active && data_write) begin
                write_while_halted <= 1'b1;
            end
        end
    end

    function automatic logic [31:0] r_type(input logic [5:0] funct, input logic [4:0] rd,
                                           input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] shamt);
        return {6'h00, rs, rt, rd, shamt, funct};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rt,
                                           input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // J to a word of the program, same 256 MB region
    function automatic logic [31:0] j_type(input int word_index);
        logic [31:0] target;
        target = reset_vector + word_index * 4;
        return {6'h02, target[27:2]};
    endfunction

    task automatic check_value(input string signal_name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: %s is %h, expected %h", signal_name, actual, expected);
            errors++;
        end
    endtask

    task automatic build_table();
        for (int i = 0; i < 5; i++) begin
            rows[i] = '0;
        end
        // t0 = 0x12345678, t1 = 0x800000f0
        names[0] = "rtype_arith_logic";
        rows[0].words[0] = i_type(6'h0f, 8, 0, 16'h1234);
        rows[0].words[1] = i_type(6'h0d, 8, 8, 16'h5678);
        rows[0].words[2] = i_type(6'h0f, 9, 0, 16'h8000);
        rows[0].words[3] = i_type(6'h0d, 9, 9, 16'h00f0);
        rows[0].words[4] = r_type(6'h21, 10, 8, 9, 0);
        rows[0].words[5] = r_type(6'h23, 11, 8, 9, 0);
        rows[0].words[6] = r_type(6'h24, 12, 10, 11, 0);
        rows[0].words[7] = r_type(6'h25, 13, 8, 9, 0);
        rows[0].words[8] = r_type(6'h26, 14, 12, 13, 0);
        rows[0].words[9] = r_type(6'h2a, 15, 9, 8, 0);
        rows[0].words[10] = r_type(6'h2b, 16, 9, 8, 0);
        rows[0].words[11] = r_type(6'h21, 2, 14, 15, 0);
        rows[0].words[12] = r_type(6'h21, 2, 2, 16, 0);
        rows[0].words[13] = r_type(6'h08, 0, 0, 0, 0);
        rows[0].expected_v0 = 32'h000003f1;
        // t0 = -16 drives every shift
        names[1] = "imm_and_shifts";
        rows[1].words[0] = i_type(6'h09, 8, 0, 16'hfff0);
        rows[1].words[1] = i_type(6'h0c, 9, 8, 16'hff0f);
        rows[1].words[2] = i_type(6'h0a, 10, 8, 16'h0005);
        rows[1].words[3] = i_type(6'h0b, 11, 8, 16'h0005);
        rows[1].words[4] = r_type(6'h00, 12, 0, 9, 4);
        rows[1].words[5] = r_type(6'h02, 13, 0, 8, 28);
        rows[1].words[6] = r_type(6'h03, 14, 0, 8, 4);
        rows[1].words[7] = r_type(6'h04, 15, 10, 12, 0);
        rows[1].words[8] = r_type(6'h06, 16, 13, 14, 0);
        rows[1].words[9] = r_type(6'h07, 17, 10, 8, 0);
        rows[1].words[10] = r_type(6'h26, 2, 15, 16, 0);
        rows[1].words[11] = r_type(6'h21, 2, 2, 17, 0);
        rows[1].words[12] = r_type(6'h21, 2, 2, 11, 0);
        rows[1].words[13] = r_type(6'h08, 0, 0, 0, 0);
        rows[1].expected_v0 = 32'h001e1ff7;
        // Store at 0x40 + 8, load back from 0x50 - 8
        names[2] = "load_store";
        rows[2].words[0] = i_type(6'h0f, 8, 0, 16'hcafe);
        rows[2].words[1] = i_type(6'h0d, 8, 8, 16'hf00d);
        rows[2].words[2] = i_type(6'h09, 9, 0, 16'h0040);
        rows[2].words[3] = i_type(6'h2b, 8, 9, 16'h0008);
        rows[2].words[4] = i_type(6'h09, 10, 0, 16'h0050);
        rows[2].words[5] = i_type(6'h23, 2, 10, 16'hfff8);
        rows[2].words[6] = r_type(6'h08, 0, 0, 0, 0);
        rows[2].expected_v0 = 32'hcafef00d;
        rows[2].expected_reads = 8'd1;
        rows[2].expected_writes = 8'd1;
        // Skipped words add 0x100, delay slots add 1
        names[3] = "branch_delay_slots";
        rows[3].words[0] = i_type(6'h09, 8, 0, 16'h0005);
        rows[3].words[1] = i_type(6'h09, 9, 0, 16'h0005);
        rows[3].words[2] = i_type(6'h04, 9, 8, 16'h0002);
        rows[3].words[3] = i_type(6'h09, 2, 2, 16'h0001);
        rows[3].words[4] = i_type(6'h09, 2, 2, 16'h0100);
        rows[3].words[5] = i_type(6'h05, 9, 8, 16'h0004);
        rows[3].words[6] = i_type(6'h09, 2, 2, 16'h0001);
        rows[3].words[7] = i_type(6'h09, 2, 2, 16'h0010);
        rows[3].words[8] = j_type(11);
        rows[3].words[9] = i_type(6'h09, 2, 2, 16'h0001);
        rows[3].words[10] = i_type(6'h09, 2, 2, 16'h0100);
        rows[3].words[11] = r_type(6'h08, 0, 0, 0, 0);
        rows[3].expected_v0 = 32'h00000013;
        names[4] = "rtype_with_stall";
        rows[4] = rows[0];
        rows[4].stall = 1'b1;
    endtask

    task automatic run_test(input int index);
        int cycles;
        int errors_before;
        errors_before = errors;
        @(negedge clk);
        reset = 1'b1;
        clk_enable = 1'b1;
        i_memory.clear();
        for (int k = 0; k < 16; k++) begin
            i_memory.load_word(k, rows[index].words[k]);
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_value("active", {31'b0, active}, 32'h1);
        check_value("register_v0", register_v0, 32'h0);
        cycles = 0;
        while (active && cycles < 500) begin
            @(negedge clk);
            clk_enable = rows[index].stall ? (($random(seed) & 3) != 0) : 1'b1;
            cycles++;
        end
        if (active) begin
            $display("Timeout: %s did not halt within 500 cycles", names[index]);
            errors++;
        end else begin
            check_value("register_v0", register_v0, rows[index].expected_v0);
        end
        clk_enable = 1'b1;
        repeat (4) @(negedge clk);
        check_value("active", {31'b0, active}, 32'h0);
        check_value("data_write_after_halt", {31'b0, write_while_halted}, 32'h0);
        check_value("data_read_count", reads_seen, {24'h0, rows[index].expected_reads});
        check_value("data_write_count", writes_seen, {24'h0, rows[index].expected_writes});
        if (errors == errors_before) begin
            passed++;
            $display("%s: passed", names[index]);
        end else begin
            failed++;
            $display("%s: failed", names[index]);
        end
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        clk_enable = 1'b0;
        seed = 32'h910a;
        errors = 0;
        passed = 0;
        failed = 0;
        build_table();
        for (int i = 0; i < 5; i++) begin
            run_test(i);
        end
        $display("Tests passed: %0d, failed: %0d", passed, failed);
        if (failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: all.f
source/mips_pkg.sv
source/mips_decoder.sv
source/mips_register_file.sv
source/mips_alu.sv
source/mips_pc_unit.sv
source/mips_cpu_harvard.sv
test/mips_tb_memory.sv
test/mips_cpu_tb.sv
